//--- include/udiv_macros.svh
/*
 * Shared build values for the UART divider: serial bit period
 * in clock cycles and the operand width.
 */
`ifndef UDIV_MACROS_SVH
`define UDIV_MACROS_SVH

// clocks per serial bit, kept small for fast simulation
`define UDIV_CLKS_PER_BIT 16

// dividend, divisor, quotient and remainder width
`define UDIV_OPND_W 16

`endif

//--- logic/udiv_pkg.sv
/*
 * Types for the UART divider: operand type and the state
 * encodings of receiver, transmitter, divider and controller.
 */
`include "udiv_macros.svh"

package udiv_pkg;

    typedef logic [`UDIV_OPND_W-1:0] operand_t; // unsigned operand

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_e;

    typedef enum logic [1:0] {
        CTRL_COLLECT, // waiting for operand bytes
        CTRL_DIVIDE,
        CTRL_SEND,
        CTRL_WAIT_TX
    } ctrl_state_e;

endpackage

//--- logic/uart_rx.sv
/*
 * UART receiver, 8N1, sampling each bit at mid period.
 * Flags a low stop bit with rx_err instead of rx_valid.
 */
`timescale 1ns/1ns
`include "udiv_macros.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       rx_err
);
    import udiv_pkg::*;

    localparam int CLKS  = `UDIV_CLKS_PER_BIT;
    localparam int TMR_W = $clog2(CLKS);

    rx_state_e        state;
    logic [TMR_W-1:0] tmr;     // counts down to the sample point
    logic [2:0]       bit_cnt;
    logic             rxd_m;   // metastability stage
    logic             rxd_s;
    logic             rxd_q;   // previous synced level for edge detect

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rxd_m    <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_q    <= 1'b1;
            state    <= RX_IDLE;
            tmr      <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
            rx_err   <= 1'b0;
        end else begin
            rxd_m    <= rxd;
            rxd_s    <= rxd_m;
            rxd_q    <= rxd_s;
            rx_valid <= 1'b0;
            rx_err   <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rxd_q && !rxd_s) begin // falling edge starts a frame
                        tmr   <= TMR_W'(CLKS / 2 - 1);
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (tmr == '0) begin
                        tmr     <= TMR_W'(CLKS - 1);
                        bit_cnt <= '0;
                        state   <= rxd_s ? RX_IDLE : RX_DATA; // glitch goes back to idle
                    end else begin
                        tmr <= tmr - 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tmr == '0) begin
                        tmr     <= TMR_W'(CLKS - 1);
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tmr <= tmr - 1'b1;
                    end
                end
                default: begin
                    if (tmr == '0) begin
                        rx_valid <= rxd_s;
                        rx_err   <= !rxd_s; // framing error
                        state    <= RX_IDLE;
                    end else begin
                        tmr <= tmr - 1'b1;
                    end
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && tmr == '0) begin
            rx_byte <= {rxd_s, rx_byte[7:1]};
        end
    end

endmodule

//--- logic/uart_tx.sv
/*
 * UART transmitter, 8N1, with a busy flag over the whole frame.
 */
`timescale 1ns/1ns
`include "udiv_macros.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       txd,
    output logic       tx_busy
);
    import udiv_pkg::*;

    localparam int CLKS  = `UDIV_CLKS_PER_BIT;
    localparam int TMR_W = $clog2(CLKS);

    tx_state_e        state;
    logic [TMR_W-1:0] tmr;
    logic [2:0]       bit_cnt;
    logic [7:0]       shreg;   // bits still to send
    logic             bit_end;

    assign bit_end = (tmr == '0);
    assign tx_busy = (state != TX_IDLE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= TX_IDLE;
            tmr     <= '0;
            bit_cnt <= '0;
            txd     <= 1'b1;
        end else begin
            tmr <= bit_end ? TMR_W'(CLKS - 1) : tmr - 1'b1;
            case (state)
                TX_IDLE: begin
                    tmr <= TMR_W'(CLKS - 1);
                    if (tx_start) begin
                        txd   <= 1'b0; // start bit
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        txd     <= shreg[0];
                        bit_cnt <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            txd   <= 1'b1; // stop bit
                            state <= TX_STOP;
                        end else begin
                            txd <= shreg[1];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shreg <= tx_byte;
        end else if (state == TX_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

//--- logic/seq_divider.sv
/*
 * Restoring shift-subtract divider, unsigned.
 * One quotient bit per clock, done pulses 17 cycles after start.
 */
`timescale 1ns/1ns
`include "udiv_macros.svh"

module seq_divider #(
    parameter int OPND_W = `UDIV_OPND_W
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  udiv_pkg::operand_t dividend,
    input  udiv_pkg::operand_t divisor,
    output udiv_pkg::operand_t quotient,
    output udiv_pkg::operand_t remainder,
    output logic               done
);
    import udiv_pkg::*;

    localparam int CNT_W = $clog2(OPND_W + 1);

    div_state_e          state;
    logic [CNT_W-1:0]    cnt;     // iterations left
    logic [2*OPND_W-1:0] acc;     // partial remainder : dividend
    logic [2*OPND_W-1:0] acc_sh;
    logic [OPND_W-1:0]   dvsr;
    logic [OPND_W-1:0]   quo;
    logic [OPND_W:0]     diff;    // extra bit holds the borrow
    logic                fits;

    assign acc_sh = acc << 1;
    assign diff   = {1'b0, acc_sh[2*OPND_W-1:OPND_W]} - {1'b0, dvsr};
    assign fits   = !diff[OPND_W];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        cnt   <= CNT_W'(OPND_W);
                        state <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == CNT_W'(1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            acc  <= {{OPND_W{1'b0}}, dividend};
            dvsr <= divisor;
            quo  <= '0;
        end else if (state == DIV_RUN) begin
            acc <= fits ? {diff[OPND_W-1:0], acc_sh[OPND_W-1:0]} : acc_sh; // restore on borrow
            quo <= {quo[OPND_W-2:0], fits};
        end
    end

    assign quotient  = quo;
    assign remainder = acc[2*OPND_W-1:OPND_W];
    assign done      = (state == DIV_DONE);

endmodule

//--- logic/div_ctrl.sv
/*
 * Command controller: collects four operand bytes, runs the divider
 * and sends quotient and remainder back as four bytes.
 */
`timescale 1ns/1ns
`include "udiv_macros.svh"

module div_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         rx_byte,
    input  logic               rx_valid,
    input  logic               rx_err,
    input  logic               tx_busy,
    output logic               tx_start,
    output logic [7:0]         tx_byte,
    output logic               start,
    output udiv_pkg::operand_t dividend,
    output udiv_pkg::operand_t divisor,
    input  udiv_pkg::operand_t quotient,
    input  udiv_pkg::operand_t remainder,
    input  logic               done,
    output udiv_pkg::operand_t result,
    output logic               busy
);
    import udiv_pkg::*;

    ctrl_state_e                state;
    logic [1:0]                 byte_cnt; // rx byte index, then tx byte index
    logic [2*`UDIV_OPND_W-1:0]  send_buf; // {remainder, quotient}, lowest byte first

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= CTRL_COLLECT;
            byte_cnt <= '0;
            start    <= 1'b0;
            tx_start <= 1'b0;
            busy     <= 1'b0;
            result   <= '0;
        end else begin
            start    <= 1'b0;
            tx_start <= 1'b0;
            case (state)
                CTRL_COLLECT: begin
                    if (rx_err) begin
                        byte_cnt <= '0; // next byte opens a new command
                    end else if (rx_valid) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            start <= 1'b1;
                            busy  <= 1'b1;
                            state <= CTRL_DIVIDE;
                        end
                    end
                end
                CTRL_DIVIDE: begin
                    if (done) begin
                        result <= quotient;
                        state  <= CTRL_SEND;
                    end
                end
                CTRL_SEND: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        byte_cnt <= byte_cnt + 2'd1;
                        state    <= CTRL_WAIT_TX;
                    end
                end
                default: begin
                    // tx_busy is still low in the tx_start cycle
                    if (!tx_busy && !tx_start) begin
                        if (byte_cnt == 2'd0) begin // wrapped after fourth byte
                            busy  <= 1'b0;
                            state <= CTRL_COLLECT;
                        end else begin
                            state <= CTRL_SEND;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CTRL_COLLECT && rx_valid) begin
            case (byte_cnt)
                2'd0:    dividend[7:0]              <= rx_byte;
                2'd1:    dividend[`UDIV_OPND_W-1:8] <= rx_byte;
                2'd2:    divisor[7:0]               <= rx_byte;
                default: divisor[`UDIV_OPND_W-1:8]  <= rx_byte;
            endcase
        end
        if (state == CTRL_DIVIDE && done) begin
            send_buf <= {remainder, quotient};
        end else if (state == CTRL_SEND && !tx_busy) begin
            tx_byte  <= send_buf[7:0];
            send_buf <= send_buf >> 8;
        end
    end

endmodule

//--- logic/uart_div_top.sv
/*
 * Serial divider top: UART receiver, controller, divider
 * and UART transmitter.
 */
`timescale 1ns/1ns
`include "udiv_macros.svh"

module uart_div_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               rxd,
    output logic               txd,
    output udiv_pkg::operand_t result,
    output logic               busy
);
    import udiv_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       rx_err;
    logic [7:0] tx_byte;
    logic       tx_start;
    logic       tx_busy;
    logic       div_start;
    logic       div_done;
    operand_t   dividend;
    operand_t   divisor;
    operand_t   quotient;
    operand_t   remainder;

    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .rxd      (rxd),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_err   (rx_err)
    );

    div_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .rx_err    (rx_err),
        .tx_busy   (tx_busy),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .start     (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done),
        .result    (result),
        .busy      (busy)
    );

    seq_divider #(
        .OPND_W (`UDIV_OPND_W)
    ) u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

endmodule

//--- dv/tb_uart_div.sv
/*
 * Directed testbench for the UART divider: serial driver and monitor,
 * operand and byte compare tasks, LFSR operands and a watchdog.
 */
`timescale 1ns/1ns
`include "udiv_macros.svh"

module tb_uart_div;
    import udiv_pkg::*;

    localparam int CLKS     = `UDIV_CLKS_PER_BIT;
    localparam int N_CMDS   = 17;              // commands over all tests
    localparam int WD_CYC   = N_CMDS * 14 * 10 * CLKS + 5000;
    localparam int RX_WAIT  = 60 * CLKS;       // covers four rx frames plus divide
    localparam int IDLE_MAX = 4 * CLKS + 50;

    logic       clk;
    logic       rst;
    logic       rxd;
    logic       txd;
    operand_t   result;
    logic       busy;

    int         value_errs;
    int         proto_errs;
    logic [31:0] lfsr_state;
    logic [7:0] got_bytes [4];  // bytes seen on txd for one command
    bit         got_ok;

    uart_div_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .rxd    (rxd),
        .txd    (txd),
        .result (result),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WD_CYC);
        $display("tests failed");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_operand(output operand_t value);
        value = '0;
        for (int i = 0; i < `UDIV_OPND_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[`UDIV_OPND_W-2:0], lfsr_state[0]}; // one step per bit
        end
    endtask

    task automatic compare_operand(input string name, input operand_t expected,
                                   input operand_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            value_errs++;
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            value_errs++;
        end
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        rxd <= b;
        repeat (CLKS - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]); // lsb first
        end
        drive_bit(1'b1);
    endtask

    task automatic send_byte_bad_stop(input logic [7:0] data);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(1'b0); // stop bit held low
        drive_bit(1'b1);
    endtask

    task automatic recv_byte(input string name, output logic [7:0] data, output bit ok);
        int waited;
        ok     = 1'b1;
        data   = '0;
        waited = 0;
        @(negedge clk);
        while (txd !== 1'b0 && waited < RX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (txd !== 1'b0) begin
            $display("%s: no start bit on txd within %0d cycles", name, RX_WAIT);
            proto_errs++;
            ok = 1'b0;
        end else begin
            repeat (CLKS / 2) @(negedge clk); // middle of start bit
            if (txd !== 1'b0) begin
                $display("%s: start bit on txd ended early", name);
                proto_errs++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge clk);
                data[i] = txd;
            end
            repeat (CLKS) @(negedge clk);
            if (txd !== 1'b1) begin
                $display("%s: stop bit on txd was low", name);
                proto_errs++;
            end
        end
    endtask

    task automatic receive_result(input string name);
        logic [7:0] b;
        bit         ok;
        got_ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            recv_byte(name, b, ok);
            got_bytes[i] = b;
            if (!ok) begin
                got_ok = 1'b0;
                break;
            end
        end
    endtask

    // busy rises with the fourth operand byte and not before
    task automatic check_busy_level(input string name, input logic expected);
        @(negedge clk);
        if (expected && busy !== 1'b1) begin
            $display("%s: busy did not rise with the fourth operand byte", name);
            proto_errs++;
        end else if (!expected && busy !== 1'b0) begin
            $display("%s: busy rose before the fourth operand byte", name);
            proto_errs++;
        end
    endtask

    task automatic wait_idle(input string name);
        int waited;
        waited = 0;
        while (busy !== 1'b0 && waited < IDLE_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (busy !== 1'b0) begin
            $display("%s: busy did not fall after the last result byte", name);
            proto_errs++;
        end
    endtask

    // txd must stay idle and busy low for the whole window
    task automatic expect_line_idle(input string name, input int cycles);
        bit seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            if (txd !== 1'b1 || busy !== 1'b0) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            $display("%s: unexpected activity on txd or busy", name);
            proto_errs++;
        end
    endtask

    task automatic run_command(input string name, input operand_t a, input operand_t b);
        operand_t exp_q;
        operand_t exp_r;
        if (b == '0) begin
            exp_q = '1; // restoring rule for a zero divisor
            exp_r = a;
        end else begin
            exp_q = a / b;
            exp_r = a % b;
        end
        fork
            begin
                send_byte(a[7:0]);
                check_busy_level(name, 1'b0);
                send_byte(a[15:8]);
                check_busy_level(name, 1'b0);
                send_byte(b[7:0]);
                check_busy_level(name, 1'b0);
                send_byte(b[15:8]);
                check_busy_level(name, 1'b1);
            end
            receive_result(name);
        join
        if (got_ok) begin
            compare_byte({name, " q_lo"}, exp_q[7:0], got_bytes[0]);
            compare_byte({name, " q_hi"}, exp_q[15:8], got_bytes[1]);
            compare_byte({name, " r_lo"}, exp_r[7:0], got_bytes[2]);
            compare_byte({name, " r_hi"}, exp_r[15:8], got_bytes[3]);
        end
        wait_idle(name);
        compare_operand({name, " result"}, exp_q, result);
    endtask

    task automatic test_basic();
        run_command("basic", 16'd1000, 16'd7);
    endtask

    task automatic test_div_zero();
        run_command("div_zero", 16'd4321, 16'd0);
        run_command("div_zero_max", 16'hffff, 16'd0);
    endtask

    task automatic test_edge_operands();
        run_command("edge_max_by_one", 16'hffff, 16'd1);
        run_command("edge_small", 16'd5, 16'd9);
        run_command("edge_equal", 16'hbeef, 16'hbeef);
    endtask

    task automatic test_frame_error();
        send_byte(8'h5a);          // three stray bytes leave the count at 3
        send_byte(8'h11);
        send_byte(8'h22);
        send_byte_bad_stop(8'hc3); // should clear the byte count
        expect_line_idle("frame_error", 6 * CLKS);
        run_command("frame_error", 16'd50000, 16'd123);
    endtask

    task automatic test_back_to_back();
        operand_t a;
        operand_t b;
        for (int i = 0; i < 10; i++) begin
            draw_operand(a);
            do begin
                draw_operand(b);
            end while (b == '0);
            run_command($sformatf("back_to_back[%0d]", i), a, b);
        end
    endtask

    initial begin
        rst        = 1'b0;
        rxd        = 1'b1;
        value_errs = 0;
        proto_errs = 0;
        got_ok     = 1'b0;
        lfsr_state = 32'h3506_09b3;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(negedge clk);
        compare_operand("reset result", '0, result);
        if (txd !== 1'b1 || busy !== 1'b0) begin
            $display("reset: txd not idle or busy high after reset");
            proto_errs++;
        end

        test_basic();
        test_div_zero();
        test_edge_operands();
        test_frame_error();
        test_back_to_back();

        $display("summary: %0d value errors, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
logic/udiv_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/seq_divider.sv
logic/div_ctrl.sv
logic/uart_div_top.sv
dv/tb_uart_div.sv

//--- run_sim.sh
#!/bin/sh
# Build the UART divider testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_uart_div \
    --Mdir obj_dir -o sim_tb_uart_div
./obj_dir/sim_tb_uart_div | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
